//--- ieu_types_pkg.sv
/* Data, address and register-index widths of the 32-bit execute stage.
   Referenced by scope from every RTL unit and the testbench. */
package ieu_types_pkg;

   // Operand and result width
   localparam int DATA_W = 32;

   // Instruction word address, byte address without bits 1..0
   localparam int PC_W = DATA_W - 2;

   // Register file index
   localparam int REG_AW = 5;

   // Shift amount taken from the low bits of operand 2
   localparam int SHAMT_W = 5;

   // One operand or one result
   typedef logic [DATA_W-1:0] data_t;

   // Word address of an instruction
   typedef logic [PC_W-1:0] pc_t;

   // Register number
   typedef logic [REG_AW-1:0] reg_addr_t;

endpackage

//--- ieu_op_pkg.sv
/* Opcode bus layout of the logic and arithmetic units, and the flush FSM states.
   Bit positions index the one-hot opcode buses coming from decode. */
package ieu_op_pkg;

   // Logic unit opcode bus
   localparam int LU_OPW = 6;

   localparam int LU_AND = 0;
   localparam int LU_OR  = 1;
   localparam int LU_XOR = 2;
   localparam int LU_SLL = 3;  // Shift left logical
   localparam int LU_SRL = 4;  // Shift right logical
   localparam int LU_SRA = 5;  // Shift right arithmetic

   typedef logic [LU_OPW-1:0] lu_opc_t;

   // Arithmetic unit opcode bus
   localparam int AU_OPW = 3;

   localparam int AU_ADD = 0;
   localparam int AU_SUB = 1;
   localparam int AU_CMP = 2;  // Sets the condition flag only

   typedef logic [AU_OPW-1:0] au_opc_t;

   // Flush request FSM
   typedef enum logic [0:0] {
      FLS_IDLE = 1'b0,
      FLS_HOLD = 1'b1   // Flush raised, waiting for the acknowledge
   } fls_state_t;

endpackage

//--- ieu_logic_unit.sv
/* Bitwise and shift unit of the execute stage, purely combinational.
   One result is selected by the one-hot logic opcode bus. */
`timescale 1ns/1ns

module ieu_logic_unit (
   input  ieu_types_pkg::data_t   operand_1,
   input  ieu_types_pkg::data_t   operand_2,
   input  ieu_op_pkg::lu_opc_t    lu_opc,
   output ieu_types_pkg::data_t   lu_result,
   output logic                   lu_sel
);

   localparam int DW = ieu_types_pkg::DATA_W;

   logic [ieu_types_pkg::SHAMT_W-1:0] shamt;
   ieu_types_pkg::data_t res_and;
   ieu_types_pkg::data_t res_or;
   ieu_types_pkg::data_t res_xor;
   ieu_types_pkg::data_t res_sll;
   ieu_types_pkg::data_t res_srl;
   ieu_types_pkg::data_t res_sra;

   assign shamt = operand_2[ieu_types_pkg::SHAMT_W-1:0];  // Upper bits ignored

   assign res_and = operand_1 & operand_2;
   assign res_or  = operand_1 | operand_2;
   assign res_xor = operand_1 ^ operand_2;
   assign res_sll = operand_1 << shamt;
   assign res_srl = operand_1 >> shamt;
   assign res_sra = $signed(operand_1) >>> shamt;  // Sign bit fills from the left

   // AND-OR select, opcode bus is one-hot
   assign lu_result =
      ({DW{lu_opc[ieu_op_pkg::LU_AND]}} & res_and) |
      ({DW{lu_opc[ieu_op_pkg::LU_OR]}}  & res_or)  |
      ({DW{lu_opc[ieu_op_pkg::LU_XOR]}} & res_xor) |
      ({DW{lu_opc[ieu_op_pkg::LU_SLL]}} & res_sll) |
      ({DW{lu_opc[ieu_op_pkg::LU_SRL]}} & res_srl) |
      ({DW{lu_opc[ieu_op_pkg::LU_SRA]}} & res_sra);

   assign lu_sel = |lu_opc;  // Result goes to the register file mux

   // Decode never asks for two logic operations at once
   always_comb begin
      if (!$isunknown(lu_opc)) begin
         a_lu_opc_onehot: assert final ($onehot0(lu_opc))
            else $error("logic opcode bus not one-hot: %b", lu_opc);
      end
   end

endmodule

//--- ieu_arith_unit.sv
/* Add, subtract and compare unit, purely combinational.
   A single adder serves all three opcodes; compare only drives the condition flag. */
`timescale 1ns/1ns

module ieu_arith_unit (
   input  ieu_types_pkg::data_t   operand_1,
   input  ieu_types_pkg::data_t   operand_2,
   input  ieu_op_pkg::au_opc_t    au_opc,
   input  logic                   cmp_eq,
   input  logic                   cmp_signed,
   output ieu_types_pkg::data_t   au_result,
   output logic                   au_sel,
   output logic                   cc_nxt,
   output logic                   cc_we
);

   localparam int DW = ieu_types_pkg::DATA_W;

   logic                  op_sub;
   ieu_types_pkg::data_t  addend;
   logic [DW:0]           sum;      // Carry out in the top bit
   logic                  carry;
   logic                  is_eq;
   logic                  lt_u;
   logic                  lt_s;

   // Compare works on the difference
   assign op_sub = au_opc[ieu_op_pkg::AU_SUB] | au_opc[ieu_op_pkg::AU_CMP];

   // Two's complement subtract as invert plus carry in
   assign addend = op_sub ? ~operand_2 : operand_2;
   assign sum    = {1'b0, operand_1} + {1'b0, addend} + {{DW{1'b0}}, op_sub};
   assign carry  = sum[DW];

   assign au_result = sum[DW-1:0];  // Wraps on overflow

   // Flag outcomes from the difference
   assign is_eq = (sum[DW-1:0] == '0);
   assign lt_u  = ~carry;  // Borrow out means op1 < op2
   always_comb begin
      if (operand_1[DW-1] != operand_2[DW-1]) begin
         lt_s = operand_1[DW-1];  // Signs differ, negative one is smaller
      end else begin
         lt_s = sum[DW-1];
      end
   end

   always_comb begin
      if (cmp_eq) begin
         cc_nxt = is_eq;
      end else if (cmp_signed) begin
         cc_nxt = lt_s;
      end else begin
         cc_nxt = lt_u;
      end
   end

   assign cc_we  = au_opc[ieu_op_pkg::AU_CMP];
   assign au_sel = au_opc[ieu_op_pkg::AU_ADD] | au_opc[ieu_op_pkg::AU_SUB];  // Not compare

endmodule

//--- ieu_spec_check.sv
/* Speculation checker: detects mispredicted branches and returns on commit,
   holds the flush and its target until the fetch unit acknowledges. */
`timescale 1ns/1ns

module ieu_spec_check (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   commit,
   input  logic                   jmprel,
   input  logic                   jmpfar,
   input  logic                   ret,
   input  logic                   specul_bcc,
   input  logic                   cc,
   input  ieu_types_pkg::pc_t     specul_tgt,
   input  ieu_types_pkg::pc_t     epc_pc,
   input  ieu_types_pkg::data_t   operand_1,
   input  logic                   specul_flush_ack,
   output logic                   specul_flush,
   output ieu_types_pkg::pc_t     flush_tgt,
   output logic                   hold,
   output logic                   bpu_wb,
   output logic                   bpu_wb_hit
);

   localparam int AW = ieu_types_pkg::PC_W;

   ieu_op_pkg::fls_state_t state_q;
   ieu_op_pkg::fls_state_t state_nxt;
   ieu_types_pkg::pc_t     far_tgt;
   ieu_types_pkg::pc_t     tgt_nxt;
   ieu_types_pkg::pc_t     tgt_q;
   logic                   flush_nxt;

   assign far_tgt = operand_1[ieu_types_pkg::DATA_W-1:2];  // No alignment check

   // Taken bit against the flag and predicted target against the register
   assign flush_nxt = commit & ((jmprel & (specul_bcc != cc)) |
                                (jmpfar & (specul_tgt != far_tgt)) |
                                ret);

   assign tgt_nxt = ({AW{jmprel}} & specul_tgt) |
                    ({AW{jmpfar}} & far_tgt) |
                    ({AW{ret}} & epc_pc);

   always_comb begin
      state_nxt = state_q;
      if (flush_nxt) begin
         state_nxt = ieu_op_pkg::FLS_HOLD;  // Also covers a new flush in the ack cycle
      end else if (specul_flush_ack) begin
         state_nxt = ieu_op_pkg::FLS_IDLE;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= ieu_op_pkg::FLS_IDLE;
      end else begin
         state_q <= state_nxt;
      end
   end

   always_ff @(posedge clk) begin
      if (flush_nxt) begin
         tgt_q <= tgt_nxt;
      end
   end

   // Input opens in the ack cycle
   assign hold = (state_q == ieu_op_pkg::FLS_HOLD) & ~specul_flush_ack;

   assign specul_flush = hold | flush_nxt;
   assign flush_tgt    = hold ? tgt_q : tgt_nxt;

   // Predictor feedback
   assign bpu_wb     = commit & (jmprel | jmpfar);
   assign bpu_wb_hit = ~specul_flush;

   a_redirect_onehot: assert property (@(posedge clk) disable iff (!rst_n)
      commit |-> $onehot0({jmprel, jmpfar, ret}))
      else $error("more than one redirect kind on commit");

   a_tgt_stable: assert property (@(posedge clk) disable iff (!rst_n)
      specul_flush |=> specul_flush_ack || (specul_flush && $stable(flush_tgt)))
      else $error("flush dropped or target changed before the acknowledge");

endmodule

//--- ieu_writeback.sv
/* Register-file write port of the execute stage: link address, result mux
   and write enable, all combinational in the commit cycle. */
`timescale 1ns/1ns

module ieu_writeback (
   input  logic                        commit,
   input  logic                        wb_regf,
   input  logic                        jmplink,
   input  ieu_types_pkg::reg_addr_t    wb_reg_addr,
   input  ieu_types_pkg::pc_t          insn_pc,
   input  ieu_types_pkg::data_t        lu_result,
   input  ieu_types_pkg::data_t        au_result,
   input  logic                        lu_sel,
   input  logic                        au_sel,
   output ieu_types_pkg::data_t        regf_din,
   output ieu_types_pkg::reg_addr_t    regf_din_addr,
   output logic                        regf_we
);

   localparam int DW = ieu_types_pkg::DATA_W;

   ieu_types_pkg::pc_t    link_pc;
   ieu_types_pkg::data_t  link_addr;

   // Next instruction after the jump, as a byte address
   assign link_pc   = insn_pc + ieu_types_pkg::pc_t'(1);
   assign link_addr = {link_pc, 2'b00};

   assign regf_din = ({DW{lu_sel}}  & lu_result) |
                     ({DW{au_sel}}  & au_result) |
                     ({DW{jmplink}} & link_addr);

   assign regf_din_addr = wb_reg_addr;
   assign regf_we       = commit & wb_regf;

   // Only one source may drive the write data
   always_comb begin
      if (regf_we) begin
         a_wb_sel_mutex: assert final ($onehot0({lu_sel, au_sel, jmplink}))
            else $error("register write data selects overlap: lu %b au %b link %b",
                        lu_sel, au_sel, jmplink);
      end
   end

endmodule

//--- ieu.sv
/* Integer execute stage top level: logic and arithmetic units, writeback mux
   and speculation checker behind a valid/ready instruction port. */
`timescale 1ns/1ns

module ieu (
   input  logic                        clk,
   input  logic                        rst_n,
   input  logic                        in_valid,
   output logic                        in_ready,
   input  ieu_types_pkg::data_t        operand_1,
   input  ieu_types_pkg::data_t        operand_2,
   input  ieu_op_pkg::lu_opc_t         lu_opc,
   input  ieu_op_pkg::au_opc_t         au_opc,
   input  logic                        cmp_eq,
   input  logic                        cmp_signed,
   input  logic                        wb_regf,
   input  ieu_types_pkg::reg_addr_t    wb_reg_addr,
   input  logic                        jmplink,
   input  ieu_types_pkg::pc_t          insn_pc,
   input  logic                        jmprel,
   input  logic                        jmpfar,
   input  logic                        ret,
   input  logic                        specul_bcc,
   input  ieu_types_pkg::pc_t          specul_tgt,
   input  logic                        cc,
   input  ieu_types_pkg::data_t        epc,
   output logic                        specul_flush,
   input  logic                        specul_flush_ack,
   output ieu_types_pkg::pc_t          flush_tgt,
   output ieu_types_pkg::data_t        regf_din,
   output ieu_types_pkg::reg_addr_t    regf_din_addr,
   output logic                        regf_we,
   output logic                        cc_nxt,
   output logic                        cc_we,
   output logic                        bpu_wb,
   output logic                        bpu_wb_hit
);

   logic                  commit;
   logic                  hold;
   logic                  lu_sel;
   logic                  au_sel;
   logic                  au_cc_we;
   ieu_types_pkg::data_t  lu_result;
   ieu_types_pkg::data_t  au_result;

   assign in_ready = ~hold;               // Stalled by an unacknowledged flush
   assign commit   = in_valid & in_ready;
   assign cc_we    = commit & au_cc_we;   // Flag written only by a committed compare

   ieu_logic_unit u_lu (
      .operand_1 (operand_1),
      .operand_2 (operand_2),
      .lu_opc    (lu_opc),
      .lu_result (lu_result),
      .lu_sel    (lu_sel)
   );

   ieu_arith_unit u_au (
      .operand_1  (operand_1),
      .operand_2  (operand_2),
      .au_opc     (au_opc),
      .cmp_eq     (cmp_eq),
      .cmp_signed (cmp_signed),
      .au_result  (au_result),
      .au_sel     (au_sel),
      .cc_nxt     (cc_nxt),
      .cc_we      (au_cc_we)
   );

   ieu_writeback u_wb (
      .commit        (commit),
      .wb_regf       (wb_regf),
      .jmplink       (jmplink),
      .wb_reg_addr   (wb_reg_addr),
      .insn_pc       (insn_pc),
      .lu_result     (lu_result),
      .au_result     (au_result),
      .lu_sel        (lu_sel),
      .au_sel        (au_sel),
      .regf_din      (regf_din),
      .regf_din_addr (regf_din_addr),
      .regf_we       (regf_we)
   );

   ieu_spec_check u_sc (
      .clk              (clk),
      .rst_n            (rst_n),
      .commit           (commit),
      .jmprel           (jmprel),
      .jmpfar           (jmpfar),
      .ret              (ret),
      .specul_bcc       (specul_bcc),
      .cc               (cc),
      .specul_tgt       (specul_tgt),
      .epc_pc           (epc[ieu_types_pkg::DATA_W-1:2]),  // Return target word address
      .operand_1        (operand_1),
      .specul_flush_ack (specul_flush_ack),
      .specul_flush     (specul_flush),
      .flush_tgt        (flush_tgt),
      .hold             (hold),
      .bpu_wb           (bpu_wb),
      .bpu_wb_hit       (bpu_wb_hit)
   );

endmodule

//--- tb_ieu.sv
/* Self-checking testbench for the execute stage, driven by records from ieu_cases.txt.
   Flushes are acknowledged after a random delay of one to three cycles. */
`timescale 1ns/1ns

module tb_ieu;

   logic                      clk;
   logic                      rst_n;
   logic                      in_valid;
   logic                      in_ready;
   ieu_types_pkg::data_t      operand_1;
   ieu_types_pkg::data_t      operand_2;
   ieu_op_pkg::lu_opc_t       lu_opc;
   ieu_op_pkg::au_opc_t       au_opc;
   logic                      cmp_eq;
   logic                      cmp_signed;
   logic                      wb_regf;
   ieu_types_pkg::reg_addr_t  wb_reg_addr;
   logic                      jmplink;
   ieu_types_pkg::pc_t        insn_pc;
   logic                      jmprel;
   logic                      jmpfar;
   logic                      ret;
   logic                      specul_bcc;
   ieu_types_pkg::pc_t        specul_tgt;
   logic                      cc;
   ieu_types_pkg::data_t      epc;
   logic                      specul_flush;
   logic                      specul_flush_ack;
   ieu_types_pkg::pc_t        flush_tgt;
   ieu_types_pkg::data_t      regf_din;
   ieu_types_pkg::reg_addr_t  regf_din_addr;
   logic                      regf_we;
   logic                      cc_nxt;
   logic                      cc_we;
   logic                      bpu_wb;
   logic                      bpu_wb_hit;

   // Fields of the current record
   ieu_op_pkg::lu_opc_t       f_lu;
   ieu_op_pkg::au_opc_t       f_au;
   logic [8:0]                f_flg;
   ieu_types_pkg::reg_addr_t  f_rd;
   ieu_types_pkg::data_t      f_op1;
   ieu_types_pkg::data_t      f_op2;
   ieu_types_pkg::pc_t        f_pc;
   ieu_types_pkg::pc_t        f_tgt;
   ieu_types_pkg::data_t      f_epc;
   logic                      e_we;
   ieu_types_pkg::data_t      e_din;
   logic                      e_ccwe;
   logic                      e_ccn;
   logic                      e_fl;
   ieu_types_pkg::pc_t        e_ftgt;

   string   cases[$];
   string   line;
   int      fd;
   int      rc;
   int      errors = 0;
   int      checks = 0;
   int      case_no = 0;
   int      cycles = 0;
   int      limit = 20;
   integer  seed = 32'h364d_0fd6;

   ieu dut (.*);

   always #50 clk = ~clk;

   // Watchdog limit is set once the case file is read
   always @(posedge clk) begin
      cycles++;
      if (cycles > limit) begin
         $display("timeout after %0d cycles, the DUT stopped making progress", cycles);
         $display("cases %0d, checks %0d, errors %0d", cases.size(), checks, errors);
         $display("** FAIL **");
         $finish;
      end
   end

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("[FAIL] case %0d %s got %h expected %h", case_no, name, got, exp);
      end
   endtask

   task automatic run_case(input string rec);
      int n;
      int delay;
      n = $sscanf(rec, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  f_lu, f_au, f_flg, f_rd, f_op1, f_op2, f_pc, f_tgt, f_epc,
                  e_we, e_din, e_ccwe, e_ccn, e_fl, e_ftgt);
      assert (n == 15) else begin
         errors++;
         $display("case %0d has only %0d readable fields in the case file", case_no, n);
      end
      if (n != 15) return;
      @(posedge clk);
      lu_opc      <= f_lu;
      au_opc      <= f_au;
      cmp_eq      <= f_flg[0];
      cmp_signed  <= f_flg[1];
      wb_regf     <= f_flg[2];
      jmplink     <= f_flg[3];
      jmprel      <= f_flg[4];
      jmpfar      <= f_flg[5];
      ret         <= f_flg[6];
      specul_bcc  <= f_flg[7];
      cc          <= f_flg[8];
      wb_reg_addr <= f_rd;
      operand_1   <= f_op1;
      operand_2   <= f_op2;
      insn_pc     <= f_pc;
      specul_tgt  <= f_tgt;
      epc         <= f_epc;
      in_valid    <= 1'b1;
      @(negedge clk);
      while (!in_ready) @(negedge clk);  // Commit cycle
      compare_value("regf_we", regf_we, e_we);
      if (e_we) begin
         compare_value("regf_din", regf_din, e_din);
         compare_value("regf_din_addr", regf_din_addr, f_rd);
      end
      compare_value("cc_we", cc_we, e_ccwe);
      if (e_ccwe) compare_value("cc_nxt", cc_nxt, e_ccn);
      compare_value("specul_flush", specul_flush, e_fl);
      if (e_fl) compare_value("flush_tgt", flush_tgt, e_ftgt);
      compare_value("bpu_wb", bpu_wb, f_flg[4] | f_flg[5]);  // Branches and jumps only
      if (f_flg[4] | f_flg[5]) compare_value("bpu_wb_hit", bpu_wb_hit, !e_fl);
      if (e_fl) begin
         delay = 1 + ($unsigned($random(seed)) % 3);
         @(posedge clk);
         in_valid   <= 1'b0;
         specul_tgt <= ~f_tgt;  // Redirect inputs move while the flush is held
         operand_1  <= ~f_op1;
         epc        <= ~f_epc;
         for (int i = 0; i < delay; i++) begin
            @(negedge clk);
            compare_value("in_ready", in_ready, 1'b0);  // Stalled while held
            compare_value("specul_flush", specul_flush, 1'b1);
            compare_value("flush_tgt", flush_tgt, e_ftgt);
            @(posedge clk);
         end
         specul_flush_ack <= 1'b1;
         @(negedge clk);
         compare_value("in_ready", in_ready, 1'b1);  // Opens in the ack cycle
         compare_value("specul_flush", specul_flush, 1'b0);
         @(posedge clk);
         specul_flush_ack <= 1'b0;
      end
   endtask

   initial begin
      clk = 1'b0;
      rst_n = 1'b0;
      in_valid = 1'b0;
      specul_flush_ack = 1'b0;
      operand_1 = '0;
      operand_2 = '0;
      lu_opc = '0;
      au_opc = '0;
      cmp_eq = 1'b0;
      cmp_signed = 1'b0;
      wb_regf = 1'b0;
      wb_reg_addr = '0;
      jmplink = 1'b0;
      insn_pc = '0;
      jmprel = 1'b0;
      jmpfar = 1'b0;
      ret = 1'b0;
      specul_bcc = 1'b0;
      specul_tgt = '0;
      cc = 1'b0;
      epc = '0;
      fd = $fopen("ieu_cases.txt", "r");
      assert (fd != 0) else begin
         errors++;
         $display("could not open the case file ieu_cases.txt");
      end
      if (fd != 0) begin
         while (!$feof(fd)) begin
            rc = $fgets(line, fd);
            if (rc > 1 && line.getc(0) != "#") cases.push_back(line);  // Skip header lines
         end
         $fclose(fd);
      end
      limit = 8 * cases.size() + 20;
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      compare_value("specul_flush", specul_flush, 1'b0);  // Idle after reset
      compare_value("regf_we", regf_we, 1'b0);
      compare_value("cc_we", cc_we, 1'b0);
      compare_value("bpu_wb", bpu_wb, 1'b0);
      foreach (cases[k]) begin
         case_no = k + 1;
         run_case(cases[k]);
      end
      @(posedge clk);
      in_valid <= 1'b0;
      @(posedge clk);
      $display("cases %0d, checks %0d, errors %0d", cases.size(), checks, errors);
      if (errors == 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

//--- ieu.f
ieu_types_pkg.sv
ieu_op_pkg.sv
ieu_logic_unit.sv
ieu_arith_unit.sv
ieu_spec_check.sv
ieu_writeback.sv
ieu.sv
tb_ieu.sv

//--- ieu_cases.txt
# lu au flags rd op1 op2 pc tgt epc | exp: regf_we regf_din cc_we cc_nxt flush flush_tgt
# flags: 0 cmp_eq, 1 cmp_signed, 2 wb_regf, 3 jmplink, 4 jmprel, 5 jmpfar, 6 ret, 7 bcc, 8 cc
01 0 004 01 f0f01234 0ff0ff00 00000000 00000000 00000000 1 00f01200 0 0 0 00000000
02 0 004 02 f0f01234 0ff0ff00 00000000 00000000 00000000 1 fff0ff34 0 0 0 00000000
04 0 004 03 f0f01234 0ff0ff00 00000000 00000000 00000000 1 ff00ed34 0 0 0 00000000
08 0 004 04 000000a5 00000104 00000000 00000000 00000000 1 00000a50 0 0 0 00000000
08 0 004 05 00000003 0000001f 00000000 00000000 00000000 1 80000000 0 0 0 00000000
10 0 004 06 80000010 00000004 00000000 00000000 00000000 1 08000001 0 0 0 00000000
20 0 004 07 80000010 00000004 00000000 00000000 00000000 1 f8000001 0 0 0 00000000
20 0 004 08 7fff0000 00000010 00000000 00000000 00000000 1 00007fff 0 0 0 00000000
20 0 004 09 fffffff0 00000024 00000000 00000000 00000000 1 ffffffff 0 0 0 00000000
00 1 004 0a 7fffffff 00000001 00000000 00000000 00000000 1 80000000 0 0 0 00000000
00 1 004 0b ffffffff 00000002 00000000 00000000 00000000 1 00000001 0 0 0 00000000
00 2 004 0c 00000005 00000007 00000000 00000000 00000000 1 fffffffe 0 0 0 00000000
00 2 004 0d 80000000 00000001 00000000 00000000 00000000 1 7fffffff 0 0 0 00000000
00 4 001 00 12345678 12345678 00000000 00000000 00000000 0 00000000 1 1 0 00000000
00 4 001 00 12345678 12345679 00000000 00000000 00000000 0 00000000 1 0 0 00000000
00 4 002 00 ffffffff 00000001 00000000 00000000 00000000 0 00000000 1 1 0 00000000
00 4 000 00 ffffffff 00000001 00000000 00000000 00000000 0 00000000 1 0 0 00000000
00 4 002 00 00000005 80000000 00000000 00000000 00000000 0 00000000 1 0 0 00000000
00 4 000 00 00000005 80000000 00000000 00000000 00000000 0 00000000 1 1 0 00000000
00 4 002 00 fffffffd fffffffd 00000000 00000000 00000000 0 00000000 1 0 0 00000000
00 0 00c 1f 00000000 00000000 00000400 00000000 00000000 1 00001004 0 0 0 00000000
00 0 02c 1f 00002000 00000000 00000123 00000800 00000000 1 00000490 0 0 0 00000000
00 0 190 00 00000000 00000000 00000050 00000456 00000000 0 00000000 0 0 0 00000000
00 0 010 00 00000000 00000000 00000051 00000460 00000000 0 00000000 0 0 0 00000000
00 0 090 00 00000000 00000000 00000052 00000789 00000000 0 00000000 0 0 1 00000789
00 0 110 00 00000000 00000000 00000053 0000abcd 00000000 0 00000000 0 0 1 0000abcd
00 0 020 00 00012348 00000000 00000054 00000000 00000000 0 00000000 0 0 1 000048d2
00 0 020 00 0000100b 00000000 00000055 00000402 00000000 0 00000000 0 0 0 00000000
00 0 040 00 00000000 00000000 00000056 00000000 80000104 0 00000000 0 0 1 20000041
00 0 02c 1e 00003000 00000000 00000200 00000800 00000000 1 00000804 0 0 1 00000c00
00 1 004 0f 00000010 00000020 00000000 00000000 00000000 1 00000030 0 0 0 00000000
